/* rtl/conv_pkg.sv */
// Shared definitions for the 3x3 convolution engine
// Image geometry, datapath widths, vector types and bundled control structs
`default_nettype none

package conv_pkg;

	// Image geometry
	localparam int IMAGE_WIDTH = 512;
	// One zero column on each side
	localparam int PADDED_WIDTH = IMAGE_WIDTH + 2;
	localparam int FILTER_SIZE = 3;

	// Datapath widths
	localparam int PIXEL_W = 8;
	localparam int COL_W = 10;
	localparam int ROW_SEL_W = 2;

	// Enabled cycles from the accepting edge to the output register
	localparam int PIPE_DEPTH = 10;

	typedef logic [PIXEL_W-1:0] pixel_t;
	typedef logic signed [PIXEL_W-1:0] coeff_t;
	typedef logic [COL_W-1:0] col_t;
	typedef logic [ROW_SEL_W-1:0] row_sel_t;
	// Pre-added outer pair times coefficient plus center term, with headroom
	typedef logic signed [2*PIXEL_W+2:0] row_sum_t;
	// Sum of three row results, wide enough that it never wraps
	typedef logic signed [2*PIXEL_W+4:0] acc_t;

	// Coefficients c[row][col], c[0][0] sits in the low byte of the 72-bit bus
	typedef struct packed {
		coeff_t [FILTER_SIZE-1:0][FILTER_SIZE-1:0] c;
	} filter_t;

	// Physical row for each logical row, phys[0] oldest and phys[2] newest
	typedef struct packed {
		row_sel_t [FILTER_SIZE-1:0] phys;
	} row_map_t;

	// One pixel write into a physical row
	typedef struct packed {
		logic en;
		row_sel_t row;
		col_t addr;
		pixel_t data;
	} wr_cmd_t;

	// Window px[logical row][column], column 0 leftmost
	typedef struct packed {
		pixel_t [0:FILTER_SIZE-1][0:FILTER_SIZE-1] px;
	} window_t;

endpackage

`default_nettype wire

/* rtl/window_ctrl.sv */
// Input-side controller of the convolution engine
// Tracks column and row of the padded image, rotates the physical row map,
// and issues write and read commands along with the output-valid pipeline
`timescale 1ns/1ps
`default_nettype none

module window_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  logic i_valid,
	input  conv_pkg::pixel_t i_x,
	output conv_pkg::wr_cmd_t o_wr,
	output conv_pkg::col_t o_rd_col,
	output conv_pkg::row_map_t o_map,
	output logic o_valid
);
	import conv_pkg::*;

	// Column of the next pixel to arrive
	col_t col_q;
	// Completed rows, saturating at FILTER_SIZE-1
	logic [ROW_SEL_W-1:0] rows_q;
	// Current logical to physical row map
	row_map_t map_q;
	row_map_t map_next;

	logic last_col;
	logic new_row;
	logic out_hit;

	// Command registers, loaded on the accepting edge
	logic wr_en_q;
	row_sel_t wr_row_q;
	col_t wr_addr_q;
	pixel_t wr_data_q;
	col_t rd_col_q;
	logic cmd_valid_q;

	// Map delayed two stages so it meets the memory read data
	row_map_t map_d1;
	row_map_t map_d2;

	// Output-valid bit, one position per enabled stage after the command
	logic [PIPE_DEPTH-1:0] vld_sr;

	// True when every physical row is used exactly once
	function automatic logic map_is_perm(row_map_t m);
		logic [FILTER_SIZE-1:0] seen;
		seen = '0;
		for (int r = 0; r < FILTER_SIZE; r++) begin
			if (m.phys[r] < FILTER_SIZE) begin
				seen[m.phys[r]] = 1'b1;
			end
		end
		return &seen;
	endfunction

	// ************************************************************************
	// Position tracking
	// ************************************************************************

	assign last_col = (col_q == col_t'(PADDED_WIDTH - 1));

	// Column 0 after at least one finished row opens a new physical row
	assign new_row = (col_q == '0) && (rows_q != '0);

	// Two full rows above and three columns of the current one present
	assign out_hit = (rows_q == ROW_SEL_W'(FILTER_SIZE - 1)) &&
		(col_q >= col_t'(FILTER_SIZE - 1));

	// Oldest physical row gets recycled as the newest
	always_comb begin
		map_next = map_q;
		if (new_row) begin
			for (int r = 0; r < FILTER_SIZE - 1; r++) begin
				map_next.phys[r] = map_q.phys[r + 1];
			end
			map_next.phys[FILTER_SIZE - 1] = map_q.phys[0];
		end
	end

	// ************************************************************************
	// Counters, map and valid pipeline
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			col_q <= '0;
			rows_q <= '0;
			wr_en_q <= 1'b0;
			rd_col_q <= '0;
			cmd_valid_q <= 1'b0;
			vld_sr <= '0;
			// Identity map
			for (int r = 0; r < FILTER_SIZE; r++) begin
				map_q.phys[r] <= row_sel_t'(r);
				map_d1.phys[r] <= row_sel_t'(r);
				map_d2.phys[r] <= row_sel_t'(r);
			end
		end else if (i_enable) begin
			// One write per accepted pixel, none otherwise
			wr_en_q <= i_valid;
			cmd_valid_q <= i_valid && out_hit;
			vld_sr <= {vld_sr[PIPE_DEPTH-2:0], cmd_valid_q};
			map_d1 <= map_q;
			map_d2 <= map_d1;
			if (i_valid) begin
				map_q <= map_next;
				// Window starts two columns back
				if (col_q >= col_t'(FILTER_SIZE - 1)) begin
					rd_col_q <= col_q - col_t'(FILTER_SIZE - 1);
				end else begin
					rd_col_q <= '0;
				end
				if (last_col) begin
					col_q <= '0;
					if (rows_q != ROW_SEL_W'(FILTER_SIZE - 1)) begin
						rows_q <= rows_q + 1'b1;
					end
				end else begin
					col_q <= col_q + 1'b1;
				end
			end
		end
	end

	// Write target and pixel, newest row after any rotation
	always_ff @(posedge clk) begin
		if (i_enable && i_valid) begin
			wr_row_q <= map_next.phys[FILTER_SIZE - 1];
			wr_addr_q <= col_q;
			wr_data_q <= i_x;
		end
	end

	assign o_wr = '{en: wr_en_q, row: wr_row_q, addr: wr_addr_q, data: wr_data_q};
	assign o_rd_col = rd_col_q;
	assign o_map = map_d2;
	// Held outputs are not presented while the consumer stalls
	assign o_valid = vld_sr[PIPE_DEPTH-1] & i_enable;

	a_col_range: assert property (@(posedge clk) disable iff (reset)
		col_q <= col_t'(PADDED_WIDTH - 1))
		else $error("window_ctrl column out of range %0d", col_q);

	a_map_perm: assert property (@(posedge clk) disable iff (reset)
		map_is_perm(map_q))
		else $error("window_ctrl row map is not a permutation");

endmodule

`default_nettype wire

/* rtl/line_buffer.sv */
// Three-row pixel store feeding the 3x3 window
// Each physical row is three copies of a row memory so one registered
// address reads columns a, a+1 and a+2 together; rows are then put in logical order
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
	input  logic clk,
	input  logic reset,
	input  logic i_enable,
	input  conv_pkg::wr_cmd_t i_wr,
	input  conv_pkg::col_t i_rd_col,
	input  conv_pkg::row_map_t i_map,
	output conv_pkg::window_t o_window
);
	import conv_pkg::*;

	// Leftmost window column, registered alongside the memory write
	col_t rd_addr_q;

	// Read data by physical row and tap
	pixel_t rd_data [FILTER_SIZE][FILTER_SIZE];

	// Window in logical row order
	window_t window_q;

	// ************************************************************************
	// Read address
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_addr_q <= '0;
		end else if (i_enable) begin
			rd_addr_q <= i_rd_col;
		end
	end

	// ************************************************************************
	// Row memories
	// ************************************************************************

	for (genvar p = 0; p < FILTER_SIZE; p++) begin : g_row
		for (genvar k = 0; k < FILTER_SIZE; k++) begin : g_tap
			// Column offset read by this copy
			localparam col_t TAP = col_t'(k);

			pixel_t mem [PADDED_WIDTH];

			// All three copies of a row take the same write
			always_ff @(posedge clk) begin
				if (i_enable) begin
					if (i_wr.en && (i_wr.row == row_sel_t'(p))) begin
						mem[i_wr.addr] <= i_wr.data;
					end
					rd_data[p][k] <= mem[rd_addr_q + TAP];
				end
			end
		end
	end

	// ************************************************************************
	// Window register
	// ************************************************************************

	// Physical to logical reorder with the map that matches this read
	always_ff @(posedge clk) begin
		if (i_enable) begin
			for (int r = 0; r < FILTER_SIZE; r++) begin
				for (int c = 0; c < FILTER_SIZE; c++) begin
					window_q.px[r][c] <= rd_data[i_map.phys[r]][c];
				end
			end
		end
	end

	assign o_window = window_q;

	a_wr_addr: assert property (@(posedge clk) disable iff (reset)
		i_wr.en |-> (i_wr.addr < col_t'(PADDED_WIDTH)))
		else $error("line_buffer write address %0d past row end", i_wr.addr);

endmodule

`default_nettype wire

/* rtl/symmetric_mac.sv */
// One window row of an x-symmetric filter
// Outer pixels are pre-added so two multiplies cover three taps, four stages deep
`timescale 1ns/1ps
`default_nettype none

module symmetric_mac (
	input  logic clk,
	input  logic i_enable,
	input  conv_pkg::coeff_t i_coeff_outer,
	input  conv_pkg::coeff_t i_coeff_center,
	input  conv_pkg::pixel_t i_left,
	input  conv_pkg::pixel_t i_center,
	input  conv_pkg::pixel_t i_right,
	output conv_pkg::row_sum_t o_sum
);
	import conv_pkg::*;

	// Stage 1 input registers
	coeff_t coeff_outer_q;
	coeff_t coeff_center_q;
	pixel_t left_q;
	pixel_t center_q;
	pixel_t right_q;

	// Stage 2 and 3 operands as signed values
	logic signed [PIXEL_W+1:0] outer_s2;
	logic signed [PIXEL_W+1:0] outer_s3;
	logic signed [PIXEL_W:0] center_s2;
	logic signed [PIXEL_W:0] center_s3;

	always_ff @(posedge clk) begin
		if (i_enable) begin
			// Stage 1
			left_q <= i_left;
			center_q <= i_center;
			right_q <= i_right;
			// Coefficients stay put while pixels are in flight
			coeff_outer_q <= i_coeff_outer;
			coeff_center_q <= i_coeff_center;

			// Stage 2 pre-adds the outer pair with a zero sign bit
			outer_s2 <= $signed({2'b00, left_q}) + $signed({2'b00, right_q});
			center_s2 <= $signed({1'b0, center_q});

			// Stage 3 balances the multiplier input timing
			outer_s3 <= outer_s2;
			center_s3 <= center_s2;

			// Stage 4
			o_sum <= outer_s3 * coeff_outer_q + center_s3 * coeff_center_q;
		end
	end

endmodule

`default_nettype wire

/* rtl/sum_clamp.sv */
// Reduction and output stage of the convolution engine
// Adds the three row results, saturates to an 8-bit pixel and registers it
`timescale 1ns/1ps
`default_nettype none

module sum_clamp (
	input  logic clk,
	input  logic i_enable,
	input  conv_pkg::row_sum_t [conv_pkg::FILTER_SIZE-1:0] i_row_sums,
	output conv_pkg::pixel_t o_y
);
	import conv_pkg::*;

	row_sum_t [FILTER_SIZE-1:0] row_q;
	acc_t total;
	acc_t total_q;

	// Sign-extended sum of the row results
	always_comb begin
		total = '0;
		for (int r = 0; r < FILTER_SIZE; r++) begin
			total = total + acc_t'(row_q[r]);
		end
	end

	always_ff @(posedge clk) begin
		if (i_enable) begin
			// Edge 8
			row_q <= i_row_sums;
			// Edge 9
			total_q <= total;
			// Edge 10 clamps to 0..255
			if (total_q[$bits(acc_t)-1]) begin
				o_y <= '0;
			end else if (|total_q[$bits(acc_t)-2:PIXEL_W]) begin
				o_y <= '1;
			end else begin
				o_y <= total_q[PIXEL_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/conv3x3_top.sv */
// Streaming 3x3 convolution over a zero-padded 512-pixel-wide grayscale image
// Consumer ready acts as a global pipeline enable and is mirrored on o_ready
// Expects a filter symmetric in x, so column 2 of i_f is never read
`timescale 1ns/1ps
`default_nettype none

module conv3x3_top (
	input  logic clk,
	input  logic reset,
	input  conv_pkg::filter_t i_f,
	input  logic i_valid,
	input  logic i_ready,
	input  conv_pkg::pixel_t i_x,
	output logic o_valid,
	output logic o_ready,
	output conv_pkg::pixel_t o_y
);
	import conv_pkg::*;

	// Controller to line buffer
	wr_cmd_t wr_cmd;
	col_t rd_col;
	row_map_t rd_map;

	// Line buffer to row MACs
	window_t window;

	// Row MACs to reduction
	row_sum_t [FILTER_SIZE-1:0] row_sums;

	// Ready for a new pixel whenever the consumer can take one
	assign o_ready = i_ready;

	// ************************************************************************
	// Control and storage
	// ************************************************************************

	window_ctrl ctrl_i (
		.clk(clk),
		.reset(reset),
		.i_enable(i_ready),
		.i_valid(i_valid),
		.i_x(i_x),
		.o_wr(wr_cmd),
		.o_rd_col(rd_col),
		.o_map(rd_map),
		.o_valid(o_valid)
	);

	line_buffer lb_i (
		.clk(clk),
		.reset(reset),
		.i_enable(i_ready),
		.i_wr(wr_cmd),
		.i_rd_col(rd_col),
		.i_map(rd_map),
		.o_window(window)
	);

	// ************************************************************************
	// Arithmetic
	// ************************************************************************

	// One MAC per logical window row, outer coefficient taken from column 0
	for (genvar r = 0; r < FILTER_SIZE; r++) begin : g_mac
		symmetric_mac mac_i (
			.clk(clk),
			.i_enable(i_ready),
			.i_coeff_outer(i_f.c[r][0]),
			.i_coeff_center(i_f.c[r][1]),
			.i_left(window.px[r][0]),
			.i_center(window.px[r][1]),
			.i_right(window.px[r][2]),
			.o_sum(row_sums[r])
		);
	end

	sum_clamp sum_i (
		.clk(clk),
		.i_enable(i_ready),
		.i_row_sums(row_sums),
		.o_y(o_y)
	);

endmodule

`default_nettype wire

/* verification/conv3x3_model.svh */
// Reference model for the convolution testbench
// Full nine-tap window sums over one padded frame, clamped to the pixel range
`ifndef CONV3X3_MODEL_SVH
`define CONV3X3_MODEL_SVH

// Saturate a window sum to 0..255
function automatic pixel_t clamp_pixel(input int sum);
	if (sum < 0) begin
		return '0;
	end
	if (sum > 255) begin
		return 8'd255;
	end
	return pixel_t'(sum);
endfunction

// One expected pixel per full window, rows top to bottom, columns left to right
task automatic model_frame(
	input filter_t f,
	input pixel_t px [FRAME_ROWS][PADDED_WIDTH],
	ref pixel_t q [$]
);
	int sum;
	// First window needs two rows above and two columns to the left
	for (int r = FILTER_SIZE - 1; r < FRAME_ROWS; r++) begin
		for (int c = FILTER_SIZE - 1; c < PADDED_WIDTH; c++) begin
			sum = 0;
			for (int i = 0; i < FILTER_SIZE; i++) begin
				for (int j = 0; j < FILTER_SIZE; j++) begin
					// Signed coefficient times unsigned pixel
					sum += int'(f.c[i][j]) *
						int'(px[r - (FILTER_SIZE - 1) + i][c - (FILTER_SIZE - 1) + j]);
				end
			end
			q.push_back(clamp_pixel(sum));
		end
	end
endtask

`endif

/* verification/conv3x3_tb.sv */
// Testbench for the 3x3 convolution engine
// Streams padded frames into conv3x3_top while assertions compare outputs with the model queue
`timescale 1ns/1ps
`default_nettype none

module conv3x3_tb;
	import conv_pkg::*;

	localparam int FRAME_ROWS = 4;
	// Index of the first pixel that completes a window at row 2 column 2
	localparam int FIRST_OUT = (FILTER_SIZE - 1) * PADDED_WIDTH + FILTER_SIZE - 1;
	localparam int ROW_OUTS = (FRAME_ROWS - FILTER_SIZE + 1) * IMAGE_WIDTH;
	localparam int ACCEPT_LIMIT = 100;
	localparam int DRAIN_LIMIT = 2000;

	logic clk;
	logic reset;
	filter_t i_f;
	logic i_valid;
	logic i_ready;
	pixel_t i_x;
	logic o_valid;
	logic o_ready;
	pixel_t o_y;

	pixel_t frame_px [FRAME_ROWS][PADDED_WIDTH];
	pixel_t exp_q [$];
	pixel_t exp_head;
	logic exp_avail;
	string test_name;
	// Ready held high for the whole frame
	logic steady;
	logic timed_out;
	int accepted;
	int frame_outputs;
	int total_outputs;
	int errors;

	`include "conv3x3_model.svh"

	conv3x3_top dut_i (
		.clk(clk),
		.reset(reset),
		.i_f(i_f),
		.i_valid(i_valid),
		.i_ready(i_ready),
		.i_x(i_x),
		.o_valid(o_valid),
		.o_ready(o_ready),
		.o_y(o_y)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ************************************************************************
	// Bookkeeping
	// ************************************************************************

	always @(posedge clk) begin
		if (reset) begin
			accepted <= 0;
			frame_outputs <= 0;
		end else begin
			if (i_valid && i_ready) begin
				accepted <= accepted + 1;
			end
			// Each presented output consumes one expected pixel
			if (o_valid) begin
				frame_outputs <= frame_outputs + 1;
				total_outputs <= total_outputs + 1;
				if (exp_q.size() != 0) begin
					void'(exp_q.pop_front());
				end
			end
		end
	end

	// Head of the queue, refreshed between rising edges
	always @(negedge clk) begin
		exp_avail = (exp_q.size() != 0);
		if (exp_avail) begin
			exp_head = exp_q[0];
		end
	end

	// ************************************************************************
	// Checks
	// ************************************************************************

	a_ready: assert property (@(posedge clk) o_ready == i_ready)
		else begin
			errors++;
			$display("Fail %s: expected o_ready %0b, actual %0b", test_name,
				$sampled(i_ready), $sampled(o_ready));
		end

	a_output: assert property (@(posedge clk) disable iff (reset)
		o_valid |-> (exp_avail && o_y == exp_head))
		else begin
			errors++;
			if (!$sampled(exp_avail)) begin
				$display("Extra output with nothing expected in %s", test_name);
			end else begin
				$display("Fail %s: expected %0d, actual %0d", test_name,
					$sampled(exp_head), $sampled(o_y));
			end
		end

	// No output before the first full window has entered
	a_idle: assert property (@(posedge clk) disable iff (reset)
		o_valid |-> (accepted > FIRST_OUT))
		else begin
			errors++;
			$display("Output valid before the first full window in %s", test_name);
		end

	a_stall_valid: assert property (@(posedge clk) disable iff (reset)
		!i_ready |-> !o_valid)
		else begin
			errors++;
			$display("Fail %s: expected o_valid 0 while stalled, actual %0b", test_name,
				$sampled(o_valid));
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		(!i_ready && !$isunknown(o_y)) |=> $stable(o_y))
		else begin
			errors++;
			$display("Output pixel changed while stalled in %s", test_name);
		end

	// Valid registered on the tenth edge is seen at the next sample
	a_latency: assert property (@(posedge clk) disable iff (reset)
		(steady && i_valid && i_ready && accepted == FIRST_OUT) |->
		##PIPE_DEPTH !o_valid ##1 o_valid)
		else begin
			errors++;
			$display("Output valid not %0d clocks after first window in %s",
				PIPE_DEPTH, test_name);
		end

	// ************************************************************************
	// Stimulus
	// ************************************************************************

	// Symmetric in x with coefficients in -span..span
	function automatic filter_t random_filter(input int span);
		filter_t f;
		for (int r = 0; r < FILTER_SIZE; r++) begin
			f.c[r][0] = coeff_t'(int'($urandom_range(2 * span)) - span);
			f.c[r][1] = coeff_t'(int'($urandom_range(2 * span)) - span);
			f.c[r][2] = f.c[r][0];
		end
		return f;
	endfunction

	// Same value everywhere except the center tap
	function automatic filter_t flat_filter(input int outer, input int center);
		filter_t f;
		for (int r = 0; r < FILTER_SIZE; r++) begin
			for (int c = 0; c < FILTER_SIZE; c++) begin
				f.c[r][c] = coeff_t'(outer);
			end
		end
		f.c[1][1] = coeff_t'(center);
		return f;
	endfunction

	task automatic fill_frame(input int lo);
		for (int r = 0; r < FRAME_ROWS; r++) begin
			for (int c = 0; c < PADDED_WIDTH; c++) begin
				if (c == 0 || c == PADDED_WIDTH - 1) begin
					frame_px[r][c] = '0;
				end else begin
					frame_px[r][c] = pixel_t'(lo + int'($urandom_range(255 - lo)));
				end
			end
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		i_valid = 1'b0;
		i_ready = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
	endtask

	// One frame from reset with gap and stall rates in percent
	task automatic run_frame(input string name, input filter_t f, input int lo,
		input int gap_pct, input int stall_pct);
		int guard;
		if (timed_out) begin
			return;
		end
		test_name = name;
		steady = 1'b0;
		apply_reset();
		exp_q.delete();
		i_f = f;
		fill_frame(lo);
		model_frame(f, frame_px, exp_q);
		steady = (stall_pct == 0);
		for (int p = 0; p < FRAME_ROWS * PADDED_WIDTH; p++) begin
			guard = 0;
			do begin
				@(negedge clk);
				i_x = frame_px[p / PADDED_WIDTH][p % PADDED_WIDTH];
				i_valid = ($urandom_range(99) >= gap_pct);
				i_ready = ($urandom_range(99) >= stall_pct);
				guard++;
				@(posedge clk);
			end while (!(i_valid && i_ready) && guard < ACCEPT_LIMIT);
			if (!(i_valid && i_ready)) begin
				errors++;
				timed_out = 1'b1;
				$display("Timed out handing pixel %0d to the DUT in %s", p, name);
				return;
			end
		end
		// Drain the pipeline while still stalling at random
		guard = 0;
		while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
			@(negedge clk);
			i_valid = 1'b0;
			i_ready = ($urandom_range(99) >= stall_pct);
			guard++;
		end
		@(negedge clk);
		i_ready = 1'b1;
		repeat (PIPE_DEPTH + 2) @(negedge clk);
		assert (exp_q.size() == 0)
			else begin
				errors++;
				$display("%0d expected pixels never appeared in %s", exp_q.size(), name);
			end
		assert (frame_outputs == ROW_OUTS)
			else begin
				errors++;
				$display("Fail %s: expected %0d, actual %0d", name, ROW_OUTS, frame_outputs);
			end
	endtask

	initial begin
		reset = 1'b1;
		i_f = '0;
		i_valid = 1'b0;
		i_ready = 1'b1;
		i_x = '0;
		steady = 1'b0;
		timed_out = 1'b0;
		total_outputs = 0;
		errors = 0;
		test_name = "reset";
		void'($urandom(32'hb6c51eec));

		run_frame("random_frame", random_filter(16), 0, 0, 0);
		run_frame("clamp_high", flat_filter(127, 127), 200, 0, 0);
		run_frame("clamp_low", flat_filter(1, -128), 200, 0, 0);
		run_frame("input_gaps", random_filter(16), 0, 30, 0);
		run_frame("back_pressure", random_filter(16), 0, 30, 30);

		$display("Outputs checked: %0d, errors: %0d", total_outputs, errors);
		if (errors == 0 && !timed_out) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+verification
rtl/conv_pkg.sv
rtl/window_ctrl.sv
rtl/line_buffer.sv
rtl/symmetric_mac.sv
rtl/sum_clamp.sv
rtl/conv3x3_top.sv
verification/conv3x3_tb.sv
